/* logic/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;

    // ALU operation seen by the datapath
    typedef enum logic [2:0]
    {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    // Decode-stage ALU class, classic ALUOp encoding
    typedef enum logic [1:0]
    {
        ALUC_MEM    = 2'b00,
        ALUC_BRANCH = 2'b01,
        ALUC_RTYPE  = 2'b10
    } alu_ctl_e;

    localparam logic [5:0] FUNCT_ADD = 6'h20;
    localparam logic [5:0] FUNCT_SUB = 6'h22;
    localparam logic [5:0] FUNCT_AND = 6'h24;
    localparam logic [5:0] FUNCT_OR  = 6'h25;
    localparam logic [5:0] FUNCT_SLT = 6'h2A;

    typedef struct packed
    {
        alu_ctl_e alu_ctl;
        logic     alu_src;
        logic     reg_dst;
    } ex_ctl_t;

    typedef struct packed
    {
        logic branch;
        logic mem_write;
        logic mem_read;
    } m_ctl_t;

    typedef struct packed
    {
        logic mem_to_reg;
        logic reg_write;
    } wb_ctl_t;

    typedef struct packed
    {
        logic [XLEN-1:0]  pc4;
        logic [XLEN-1:0]  instr;
        logic [XLEN-1:0]  rs_data;
        logic [XLEN-1:0]  rt_data;
        logic [XLEN-1:0]  imm;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] rd;
        ex_ctl_t          ex;
        m_ctl_t           m;
        wb_ctl_t          wb;
    } id_ex_t;

    typedef struct packed
    {
        logic             valid;
        logic [XLEN-1:0]  pc_branch;
        logic             zero;
        logic [XLEN-1:0]  alu;
        logic [XLEN-1:0]  store_data;
        logic [REG_W-1:0] dest;
        m_ctl_t           m;
        wb_ctl_t          wb;
    } ex_mem_t;

    typedef struct packed
    {
        logic             valid;
        logic [XLEN-1:0]  read_data;
        logic [XLEN-1:0]  alu;
        logic [REG_W-1:0] dest;
        wb_ctl_t          wb;
    } mem_wb_t;

    // Request toward the register file
    typedef struct packed
    {
        logic             valid;
        logic             reg_write;
        logic [REG_W-1:0] dest;
        logic [XLEN-1:0]  data;
    } wb_req_t;

endpackage

`default_nettype wire

/* logic/mips_alu.sv */
`default_nettype none

module mips_alu
    import mips_pkg::*;
(
    input  alu_op_e         i_op,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    output logic [XLEN-1:0] o_result,
    output logic            o_zero
);

    always_comb
    begin
        case (i_op)
            ALU_ADD:
            begin
                o_result = i_a + i_b;
            end
            ALU_SUB:
            begin
                o_result = i_a - i_b;
            end
            ALU_AND:
            begin
                o_result = i_a & i_b;
            end
            ALU_OR:
            begin
                o_result = i_a | i_b;
            end
            ALU_SLT:
            begin
                // Signed compare, result is 1 or 0
                o_result = ($signed(i_a) < $signed(i_b)) ? XLEN'(1) : '0;
            end
            default:
            begin
                o_result = i_a + i_b;
            end
        endcase
    end

    // beq relies on this after a subtract
    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`default_nettype none

module execute_stage
    import mips_pkg::*;
(
    input  logic    i_valid,
    input  id_ex_t  i_id_ex,
    output ex_mem_t o_ex_mem
);

    alu_op_e         alu_op;
    logic [5:0]      funct;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_zero;

    assign funct = i_id_ex.instr[5:0];

    // ALU control from the decode class and the funct field
    always_comb
    begin
        case (i_id_ex.ex.alu_ctl)
            ALUC_MEM:    alu_op = ALU_ADD;
            ALUC_BRANCH: alu_op = ALU_SUB;
            ALUC_RTYPE:
            begin
                case (funct)
                    FUNCT_ADD: alu_op = ALU_ADD;
                    FUNCT_SUB: alu_op = ALU_SUB;
                    FUNCT_AND: alu_op = ALU_AND;
                    FUNCT_OR:  alu_op = ALU_OR;
                    FUNCT_SLT: alu_op = ALU_SLT;
                    default:   alu_op = ALU_ADD;
                endcase
            end
            default:     alu_op = ALU_ADD;
        endcase
    end

    assign operand_b = i_id_ex.ex.alu_src ? i_id_ex.imm : i_id_ex.rt_data;

    mips_alu u_alu
    (
        .i_op     (alu_op),
        .i_a      (i_id_ex.rs_data),
        .i_b      (operand_b),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    always_comb
    begin
        o_ex_mem.valid      = i_valid;
        // Word offset from PC+4
        o_ex_mem.pc_branch  = i_id_ex.pc4 + {i_id_ex.imm[XLEN-3:0], 2'b00};
        o_ex_mem.zero       = alu_zero;
        o_ex_mem.alu        = alu_result;
        o_ex_mem.store_data = i_id_ex.rt_data;
        o_ex_mem.dest       = i_id_ex.ex.reg_dst ? i_id_ex.rd : i_id_ex.rt;
        o_ex_mem.m          = i_id_ex.m;
        o_ex_mem.wb         = i_id_ex.wb;
    end

endmodule

`default_nettype wire

/* logic/ex_mem_reg.sv */
`default_nettype none

module ex_mem_reg
    import mips_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  ex_mem_t i_ex_mem,
    output ex_mem_t o_ex_mem
);

    ex_mem_t ex_mem_q;

    // Whole bundle captured each cycle, only the controls see reset
    always_ff @(posedge i_clk)
    begin
        ex_mem_q <= i_ex_mem;
        if (i_rst)
        begin
            ex_mem_q.valid <= 1'b0;
            ex_mem_q.m     <= '0;
            ex_mem_q.wb    <= '0;
        end
    end

    assign o_ex_mem = ex_mem_q;

endmodule

`default_nettype wire

/* logic/memory_stage.sv */
`default_nettype none

module memory_stage
    import mips_pkg::*;
#(
    parameter int DMEM_WORDS = 256
)
(
    input  logic            i_clk,
    input  ex_mem_t         i_ex_mem,
    output mem_wb_t         o_mem_wb,
    output logic            o_branch_taken,
    output logic [XLEN-1:0] o_branch_target
);

    localparam int ADDR_W = $clog2(DMEM_WORDS);

    logic [XLEN-1:0]   dmem [DMEM_WORDS];
    logic [ADDR_W-1:0] word_addr;
    logic [XLEN-1:0]   read_data;

    // Byte address to word index
    assign word_addr = i_ex_mem.alu[ADDR_W+1:2];

    always_ff @(posedge i_clk)
    begin
        if (i_ex_mem.valid && i_ex_mem.m.mem_write)
        begin
            dmem[word_addr] <= i_ex_mem.store_data;
        end
    end

    // Asynchronous read so a following load sees the last store
    assign read_data = i_ex_mem.m.mem_read ? dmem[word_addr] : '0;

    // beq resolves here
    assign o_branch_taken  = i_ex_mem.valid && i_ex_mem.m.branch && i_ex_mem.zero;
    assign o_branch_target = i_ex_mem.pc_branch;

    always_comb
    begin
        o_mem_wb.valid     = i_ex_mem.valid;
        o_mem_wb.read_data = read_data;
        o_mem_wb.alu       = i_ex_mem.alu;
        o_mem_wb.dest      = i_ex_mem.dest;
        o_mem_wb.wb        = i_ex_mem.wb;
    end

endmodule

`default_nettype wire

/* logic/writeback_stage.sv */
`default_nettype none

module writeback_stage
    import mips_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  mem_wb_t i_mem_wb,
    output wb_req_t o_wb
);

    mem_wb_t mem_wb_q;

    // MEM/WB register
    always_ff @(posedge i_clk)
    begin
        mem_wb_q <= i_mem_wb;
        if (i_rst)
        begin
            mem_wb_q.valid <= 1'b0;
            mem_wb_q.wb    <= '0;
        end
    end

    always_comb
    begin
        o_wb.valid     = mem_wb_q.valid;
        // A bubble never writes
        o_wb.reg_write = mem_wb_q.valid && mem_wb_q.wb.reg_write;
        o_wb.dest      = mem_wb_q.dest;
        o_wb.data      = mem_wb_q.wb.mem_to_reg ? mem_wb_q.read_data : mem_wb_q.alu;
    end

endmodule

`default_nettype wire

/* logic/mips_back_end.sv */
`default_nettype none

module mips_back_end
    import mips_pkg::*;
#(
    parameter int DMEM_WORDS = 256
)
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_valid,
    input  id_ex_t          i_id_ex,
    output wb_req_t         o_wb,
    output logic            o_branch_taken,
    output logic [XLEN-1:0] o_branch_target
);

    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;

    execute_stage u_execute
    (
        .i_valid  (i_valid),
        .i_id_ex  (i_id_ex),
        .o_ex_mem (ex_mem_d)
    );

    ex_mem_reg u_ex_mem_reg
    (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_ex_mem (ex_mem_d),
        .o_ex_mem (ex_mem_q)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memory (
        .i_clk           (i_clk),
        .i_ex_mem        (ex_mem_q),
        .o_mem_wb        (mem_wb_d),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target)
    );

    // Holds MEM/WB internally
    writeback_stage u_writeback
    (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_mem_wb (mem_wb_d),
        .o_wb     (o_wb)
    );

endmodule

`default_nettype wire

/* sim/mips_back_end_tb.sv */
`default_nettype none

module mips_back_end_tb
    import mips_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20;

    typedef enum logic [1:0]
    {
        K_RTYPE,
        K_LW,
        K_SW,
        K_BEQ
    } kind_e;

    typedef struct packed
    {
        kind_e            kind;
        logic [5:0]       funct;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        logic [XLEN-1:0]  imm;
        logic [REG_W-1:0] dest;
        logic [3:0]       gap;
        logic [XLEN-1:0]  pc4;
        logic             exp_write;
        logic [XLEN-1:0]  exp_data;
        logic             exp_taken;
        logic [XLEN-1:0]  exp_target;
    } row_t;

    logic            i_clk;
    logic            i_rst;
    logic            i_valid;
    id_ex_t          i_id_ex;
    wb_req_t         o_wb;
    logic            o_branch_taken;
    logic [XLEN-1:0] o_branch_target;

    row_t            rows[$];
    logic [XLEN-1:0] ref_mem [int];
    int              errors = 0;
    int              rows_failed = 0;
    int              rows_done = 0;

    mips_back_end #(
        .DMEM_WORDS (256)
    ) dut (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_valid         (i_valid),
        .i_id_ex         (i_id_ex),
        .o_wb            (o_wb),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // Reference model evaluated in table order
    task automatic add_row(input kind_e kind, input logic [5:0] funct,
                           input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                           input logic [XLEN-1:0] imm, input logic [REG_W-1:0] dest,
                           input logic [3:0] gap);
        row_t r;
        r       = '0;
        r.kind  = kind;
        r.funct = funct;
        r.a     = a;
        r.b     = b;
        r.imm   = imm;
        r.dest  = dest;
        r.gap   = gap;
        r.pc4   = 32'h0040_0004 + 32'(rows.size() * 4);
        case (kind)
            K_RTYPE:
            begin
                r.exp_write = 1'b1;
                case (funct)
                    FUNCT_SUB: r.exp_data = a - b;
                    FUNCT_AND: r.exp_data = a & b;
                    FUNCT_OR:  r.exp_data = a | b;
                    FUNCT_SLT: r.exp_data = {31'b0, ($signed(a) < $signed(b))};
                    default:   r.exp_data = a + b;
                endcase
            end
            K_SW: ref_mem[int'((a + imm) >> 2)] = b;
            K_LW:
            begin
                r.exp_write = 1'b1;
                r.exp_data  = ref_mem[int'((a + imm) >> 2)];
            end
            default:
            begin
                r.exp_taken  = (a == b);
                r.exp_target = r.pc4 + (imm << 2);
            end
        endcase
        rows.push_back(r);
    endtask

    // Decoder role that builds the ID/EX bundle
    function automatic id_ex_t make_bundle(input row_t r);
        id_ex_t b;
        b         = '0;
        b.pc4     = r.pc4;
        b.rs_data = r.a;
        b.rt_data = r.b;
        b.imm     = r.imm;
        b.rt      = r.dest;
        b.rd      = 5'd31;
        case (r.kind)
            K_RTYPE:
            begin
                b.rt    = 5'd30;
                b.rd    = r.dest;
                b.instr = {6'h00, 5'd29, 5'd30, r.dest, 5'd0, r.funct};
                b.ex    = '{ALUC_RTYPE, 1'b0, 1'b1};
                b.wb    = '{1'b0, 1'b1};
            end
            K_LW:
            begin
                b.instr = {6'h23, 5'd29, r.dest, r.imm[15:0]};
                b.ex    = '{ALUC_MEM, 1'b1, 1'b0};
                b.m     = '{1'b0, 1'b0, 1'b1};
                b.wb    = '{1'b1, 1'b1};
            end
            K_SW:
            begin
                b.instr = {6'h2B, 5'd29, r.dest, r.imm[15:0]};
                b.ex    = '{ALUC_MEM, 1'b1, 1'b0};
                b.m     = '{1'b0, 1'b1, 1'b0};
            end
            default:
            begin
                b.instr = {6'h04, 5'd29, 5'd30, r.imm[15:0]};
                b.ex    = '{ALUC_BRANCH, 1'b0, 1'b0};
                b.m     = '{1'b1, 1'b0, 1'b0};
            end
        endcase
        return b;
    endfunction

    // Idle payload with every control set, a taken beq that also stores to word 0
    function automatic id_ex_t make_idle_bundle();
        id_ex_t b;
        b         = '0;
        b.rs_data = 32'h0000_0040;
        b.rt_data = 32'h0000_0040;
        b.ex      = '{ALUC_BRANCH, 1'b0, 1'b1};
        b.m       = '{1'b1, 1'b1, 1'b1};
        b.wb      = '{1'b0, 1'b1};
        return b;
    endfunction

    task automatic compare_field(input int row, input string what,
                                 input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        assert (got === exp)
        else
        begin
            $display("Mismatch at %0t: row %0d %s is %h, expected %h", $time, row, what, got, exp);
            errors++;
        end
    endtask

    initial
    begin : stimulus
        i_rst      <= 1'b1;
        i_valid    <= 1'b0;
        i_id_ex    <= '0;
        void'($urandom(32'heef8_8f21));
        add_row(K_RTYPE, FUNCT_ADD, $urandom(), $urandom(), '0, 5'd1, 4'd3);
        add_row(K_RTYPE, FUNCT_SUB, $urandom(), $urandom(), '0, 5'd2, 4'd1);
        add_row(K_RTYPE, FUNCT_AND, $urandom(), $urandom(), '0, 5'd3, 4'd0);
        add_row(K_RTYPE, FUNCT_OR, $urandom(), $urandom(), '0, 5'd4, 4'd2);
        add_row(K_RTYPE, FUNCT_SLT, $urandom() | 32'h8000_0000, $urandom() & 32'h7fff_ffff,
                '0, 5'd5, 4'd0);
        add_row(K_RTYPE, FUNCT_SLT, $urandom() & 32'h7fff_ffff, $urandom() | 32'h8000_0000,
                '0, 5'd6, 4'd1);
        add_row(K_RTYPE, FUNCT_SLT, $urandom() | 32'h8000_0000, $urandom() | 32'h8000_0000,
                '0, 5'd7, 4'd0);
        // Store and load back to back and then with a gap
        add_row(K_SW, 6'h00, 32'h0000_0100, $urandom(), 32'h0000_0010, 5'd8, 4'd2);
        add_row(K_LW, 6'h00, 32'h0000_0100, '0, 32'h0000_0010, 5'd9, 4'd0);
        add_row(K_SW, 6'h00, 32'h0000_0004, $urandom(), 32'hffff_fffc, 5'd10, 4'd1);
        add_row(K_LW, 6'h00, 32'hffff_fff4, '0, 32'h0000_000c, 5'd11, 4'd3);
        // beq forward, backward, not taken
        add_row(K_BEQ, 6'h00, 32'h1234_5678, 32'h1234_5678, 32'h0000_0040, 5'd0, 4'd2);
        add_row(K_BEQ, 6'h00, 32'hffff_fff0, 32'hffff_fff0, 32'hffff_fff8, 5'd0, 4'd0);
        add_row(K_BEQ, 6'h00, 32'h0000_0001, 32'h0000_0002, 32'h0000_0020, 5'd0, 4'd1);
        for (int k = 0; k < 6; k++)
        begin
            add_row(K_RTYPE, k[0] ? FUNCT_SLT : FUNCT_ADD, $urandom(), $urandom(), '0,
                    5'(12 + k), 4'd0);
        end
        add_row(K_SW, 6'h00, 32'h0000_03f0, $urandom(), 32'h0000_000c, 5'd20, 4'd0);
        add_row(K_LW, 6'h00, 32'h0000_03f0, '0, 32'h0000_000c, 5'd21, 4'd0);
        repeat (2) @(posedge i_clk);
        i_rst <= 1'b0;
        foreach (rows[i])
        begin
            repeat (rows[i].gap)
            begin
                @(posedge i_clk);
                i_valid <= 1'b0;
                i_id_ex <= make_idle_bundle();
            end
            @(posedge i_clk);
            i_valid <= 1'b1;
            i_id_ex <= make_bundle(rows[i]);
        end
        @(posedge i_clk);
        i_valid <= 1'b0;
        i_id_ex <= make_idle_bundle();
    end

    initial
    begin : result_monitor
        int              waited;
        int              errors_before;
        logic            found;
        logic            timed_out;
        logic            prev_taken;
        logic [XLEN-1:0] prev_target;
        timed_out   = 1'b0;
        prev_taken  = 1'b0;
        prev_target = '0;
        repeat (2) @(posedge i_clk);
        repeat (3)
        begin
            @(negedge i_clk);
            assert (!o_wb.valid && !o_wb.reg_write && !o_branch_taken)
            else
            begin
                $display("Mismatch at %0t: outputs active after reset with no strobe", $time);
                errors++;
            end
        end
        foreach (rows[i])
        begin
            waited        = 0;
            found         = 1'b0;
            errors_before = errors;
            while (!found && waited < TIMEOUT_CYCLES)
            begin
                @(negedge i_clk);
                waited++;
                found = o_wb.valid;
                // Branch result shows one cycle ahead of write-back
                if (!found)
                begin
                    assert (!o_wb.reg_write && !prev_taken)
                    else
                    begin
                        $display("Mismatch at %0t: bubble before row %0d writes or branches",
                                 $time, i);
                        errors++;
                    end
                    prev_taken  = o_branch_taken;
                    prev_target = o_branch_target;
                end
            end
            if (!found)
            begin
                $display("Timeout: row %0d never retired within %0d cycles", i, TIMEOUT_CYCLES);
                errors++;
                timed_out = 1'b1;
                break;
            end
            if (i > 0)
                compare_field(i, "retire spacing", 32'(waited), 32'(rows[i].gap) + 32'd1);
            compare_field(i, "reg_write", 32'(o_wb.reg_write), 32'(rows[i].exp_write));
            compare_field(i, "branch_taken", 32'(prev_taken), 32'(rows[i].exp_taken));
            if (rows[i].exp_write)
            begin
                compare_field(i, "dest", 32'(o_wb.dest), 32'(rows[i].dest));
                compare_field(i, "data", o_wb.data, rows[i].exp_data);
            end
            if (rows[i].exp_taken)
                compare_field(i, "branch_target", prev_target, rows[i].exp_target);
            prev_taken  = o_branch_taken;
            prev_target = o_branch_target;
            if (errors != errors_before)
                rows_failed++;
            rows_done++;
            $display("Row %0d %s: %s", i, rows[i].kind.name(),
                     (errors == errors_before) ? "ok" : "failed");
        end
        if (!timed_out)
        begin
            repeat (5)
            begin
                @(negedge i_clk);
                assert (!o_wb.valid && !o_wb.reg_write && !o_branch_taken)
                else
                begin
                    $display("Mismatch at %0t: extra result after the last row", $time);
                    errors++;
                end
            end
        end
        $display("Rows checked %0d of %0d, rows failed %0d, errors %0d",
                 rows_done, rows.size(), rows_failed, errors);
        if (errors == 0 && !timed_out)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* mips_back_end.f */
logic/mips_pkg.sv
logic/mips_alu.sv
logic/execute_stage.sv
logic/ex_mem_reg.sv
logic/memory_stage.sv
logic/writeback_stage.sv
logic/mips_back_end.sv
sim/mips_back_end_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module mips_back_end_tb \
    --Mdir "$BUILD_DIR" -o mips_back_end_sim \
    -f mips_back_end.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/mips_back_end_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
